//--- src/pipe_pkg.sv
package pipe_pkg;

   // data path and register file sizing
   localparam int XLEN      = 32;
   localparam int RF_ADDR_W = 5;

   // data memory holds DMEM_WORDS words, indexed by address bits above the byte offset
   localparam int DMEM_WORDS = 64;
   localparam int DMEM_AW    = $clog2(DMEM_WORDS);

   // special-purpose register file
   localparam int SPR_ADDR_W = 3;
   localparam int SPR_NUM    = 2 ** SPR_ADDR_W;

   localparam logic [XLEN-1:0] RESET_PC = 32'h100;

   // register 0 of the spr file reads back this identification value
   localparam logic [XLEN-1:0] SPR_ID = 32'h0001_0001;

   typedef enum logic [2:0] {
      OP_NOP   = 3'd0,
      OP_ALU   = 3'd1,
      OP_JAL   = 3'd2,
      OP_LOAD  = 3'd3,
      OP_STORE = 3'd4,
      OP_MFSPR = 3'd5,
      OP_MTSPR = 3'd6
   } op_e;

   // EXC_DBUS is an address outside the data memory
   typedef enum logic [2:0] {
      EXC_NONE    = 3'd0,
      EXC_ILLEGAL = 3'd1,
      EXC_SYSCALL = 3'd2,
      EXC_ALIGN   = 3'd3,
      EXC_DBUS    = 3'd4
   } cause_e;

   // result carries the ALU result, the effective address of a load or store,
   // or the spr number in its low bits
   typedef struct packed {
      op_e                  op;
      logic [RF_ADDR_W-1:0] rd;
      logic [XLEN-1:0]      pc;
      logic [XLEN-1:0]      result;
      logic [XLEN-1:0]      opb;
      logic                 exc_illegal;
      logic                 exc_syscall;
   } exec_pkt_t;

   typedef struct packed {
      logic            we;
      logic [XLEN-1:0] addr;
      logic [XLEN-1:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic [XLEN-1:0] rdata;
      logic            err_align;
      logic            err_bus;
   } mem_rsp_t;

   typedef struct packed {
      logic                  we;
      logic [SPR_ADDR_W-1:0] addr;
      logic [XLEN-1:0]       wdata;
   } spr_req_t;

   typedef struct packed {
      logic [RF_ADDR_W-1:0] rd;
      logic [XLEN-1:0]      data;
   } wb_t;

   typedef struct packed {
      cause_e          cause;
      logic [XLEN-1:0] pc;
   } exc_t;

endpackage

//--- src/pipe_spr_file.sv
`timescale 1ns/1ps

module pipe_spr_file import pipe_pkg::*; (
   input  logic            clk,
   input  logic            rst,
   input  logic            req_valid_i,
   input  spr_req_t        req_i,
   output logic            ack_o,
   output logic [XLEN-1:0] rdata_o
);

   logic [XLEN-1:0] spr [SPR_NUM];

   // entry 0 holds the identification value and is never written
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < SPR_NUM; i++) begin
            spr[i] <= (i == 0) ? SPR_ID : '0;
         end
      end else if (req_valid_i & req_i.we & (req_i.addr != '0)) begin
         spr[req_i.addr] <= req_i.wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= req_valid_i;
      end
   end

   // the read sees the value before a write in the same cycle
   always_ff @(posedge clk) begin
      if (req_valid_i) begin
         rdata_o <= spr[req_i.addr];
      end
   end

endmodule

//--- src/pipe_dmem.sv
`timescale 1ns/1ps

module pipe_dmem import pipe_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     req_valid_i,
   input  mem_req_t req_i,
   output logic     rsp_valid_o,
   output mem_rsp_t rsp_o
);

   logic               s1_valid;
   mem_req_t           s1_req;
   logic               s1_misalign;
   logic               s1_out_range;
   logic               s1_ok;
   logic [DMEM_AW-1:0] s1_idx;
   logic [XLEN-1:0]    mem [DMEM_WORDS];

   // first stage only captures the request
   always_ff @(posedge clk) begin
      if (rst) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= req_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      s1_req <= req_i;
   end

   assign s1_misalign  = (s1_req.addr[1:0] != 2'b00);
   assign s1_out_range = (s1_req.addr[XLEN-1:2] >= (XLEN-2)'(DMEM_WORDS));
   assign s1_ok        = !s1_misalign & !s1_out_range;
   assign s1_idx       = s1_req.addr[DMEM_AW+1:2];

   // second stage does the access, so a store is visible to any later load
   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_valid_o <= 1'b0;
         for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else begin
         rsp_valid_o <= s1_valid;
         if (s1_valid & s1_req.we & s1_ok) begin
            mem[s1_idx] <= s1_req.wdata;
         end
      end
   end

   // a faulting access returns zero data along with its error flags
   always_ff @(posedge clk) begin
      rsp_o.rdata     <= s1_ok ? mem[s1_idx] : '0;
      rsp_o.err_align <= s1_misalign;
      rsp_o.err_bus   <= s1_out_range;
   end

endmodule

//--- src/pipe_exec_ctrl.sv
`timescale 1ns/1ps

module pipe_exec_ctrl import pipe_pkg::*; (
   input  logic            clk,
   input  logic            rst,

   input  exec_pkt_t       issue_pkt_i,
   input  logic            issue_valid_i,
   output logic            issue_ready_o,
   input  logic            flush_i,

   output logic            mem_req_valid_o,
   output mem_req_t        mem_req_o,
   input  logic            mem_rsp_valid_i,
   input  mem_rsp_t        mem_rsp_i,

   output logic            spr_req_valid_o,
   output spr_req_t        spr_req_o,
   input  logic            spr_ack_i,
   input  logic [XLEN-1:0] spr_rdata_i,

   output logic            wb_valid_o,
   output wb_t             wb_o,
   output logic            exc_valid_o,
   output exc_t            exc_o
);

   exec_pkt_t       ctrl_pkt;
   logic            ctrl_valid;
   logic            ctrl_new;
   logic            mem_pend;
   logic            spr_pend;
   logic            run_q;
   logic            is_mem;
   logic            is_spr;
   logic            dec_exc;
   logic            mem_wait;
   logic            spr_wait;
   logic            waiting;
   logic            done;
   logic            advance;
   logic            wb_en;
   cause_e          cause;
   logic [XLEN-1:0] wb_data;

   assign is_mem  = (ctrl_pkt.op == OP_LOAD) | (ctrl_pkt.op == OP_STORE);
   assign is_spr  = (ctrl_pkt.op == OP_MFSPR) | (ctrl_pkt.op == OP_MTSPR);
   assign dec_exc = ctrl_pkt.exc_illegal | ctrl_pkt.exc_syscall;

   // an excepting instruction never reaches a unit
   assign mem_req_valid_o = ctrl_valid & ctrl_new & is_mem & !dec_exc;
   assign spr_req_valid_o = ctrl_valid & ctrl_new & is_spr & !dec_exc;

   assign mem_req_o.we    = (ctrl_pkt.op == OP_STORE);
   assign mem_req_o.addr  = ctrl_pkt.result;
   assign mem_req_o.wdata = ctrl_pkt.opb;

   assign spr_req_o.we    = (ctrl_pkt.op == OP_MTSPR);
   assign spr_req_o.addr  = ctrl_pkt.result[SPR_ADDR_W-1:0];
   assign spr_req_o.wdata = ctrl_pkt.opb;

   // a unit holds the stage from its request until the response shows up
   assign mem_wait = mem_req_valid_o | (mem_pend & !mem_rsp_valid_i);
   assign spr_wait = spr_req_valid_o | (spr_pend & !spr_ack_i);
   assign waiting  = mem_wait | spr_wait;
   assign done     = ctrl_valid & !waiting;

   assign issue_ready_o = run_q & (!ctrl_valid | done);
   assign advance       = issue_valid_i & issue_ready_o;

   // illegal beats syscall, and decode faults beat the memory faults
   always_comb begin
      cause = EXC_NONE;
      if (ctrl_pkt.exc_illegal) begin
         cause = EXC_ILLEGAL;
      end else if (ctrl_pkt.exc_syscall) begin
         cause = EXC_SYSCALL;
      end else if (is_mem & mem_rsp_valid_i & mem_rsp_i.err_align) begin
         cause = EXC_ALIGN;
      end else if (is_mem & mem_rsp_valid_i & mem_rsp_i.err_bus) begin
         cause = EXC_DBUS;
      end
   end

   always_comb begin
      case (ctrl_pkt.op)
         OP_JAL:   wb_data = ctrl_pkt.pc + XLEN'(4);
         OP_LOAD:  wb_data = mem_rsp_i.rdata;
         OP_MFSPR: wb_data = spr_rdata_i;
         default:  wb_data = ctrl_pkt.result;
      endcase
   end

   assign wb_en = ((ctrl_pkt.op == OP_ALU) | (ctrl_pkt.op == OP_JAL) |
                   (ctrl_pkt.op == OP_LOAD) | (ctrl_pkt.op == OP_MFSPR)) &
                  (ctrl_pkt.rd != '0);

   // keeps issue_ready_o low until the first edge out of reset
   always_ff @(posedge clk) begin
      if (rst) begin
         run_q <= 1'b0;
      end else begin
         run_q <= 1'b1;
      end
   end

   // an arriving instruction wins over a flush on the same edge
   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_valid <= 1'b0;
         ctrl_new   <= 1'b0;
      end else if (advance) begin
         ctrl_valid <= 1'b1;
         ctrl_new   <= 1'b1;
      end else begin
         ctrl_new <= 1'b0;
         if (flush_i | done) begin
            ctrl_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_pkt <= '{op: OP_NOP, pc: RESET_PC, default: '0};
      end else if (advance) begin
         ctrl_pkt <= issue_pkt_i;
      end
   end

   // a response that lands after a flush finds no pending bit and is dropped
   always_ff @(posedge clk) begin
      if (rst | flush_i) begin
         mem_pend <= 1'b0;
      end else if (mem_req_valid_o) begin
         mem_pend <= 1'b1;
      end else if (mem_rsp_valid_i) begin
         mem_pend <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst | flush_i) begin
         spr_pend <= 1'b0;
      end else if (spr_req_valid_o) begin
         spr_pend <= 1'b1;
      end else if (spr_ack_i) begin
         spr_pend <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_valid_o  <= 1'b0;
         exc_valid_o <= 1'b0;
      end else begin
         wb_valid_o  <= done & !flush_i & (cause == EXC_NONE) & wb_en;
         exc_valid_o <= done & !flush_i & (cause != EXC_NONE);
      end
   end

   always_ff @(posedge clk) begin
      wb_o.rd    <= ctrl_pkt.rd;
      wb_o.data  <= wb_data;
      exc_o.cause <= cause;
      exc_o.pc    <= ctrl_pkt.pc;
   end

endmodule

//--- src/pipe_tail.sv
`timescale 1ns/1ps

module pipe_tail import pipe_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  exec_pkt_t issue_pkt_i,
   input  logic      issue_valid_i,
   output logic      issue_ready_o,
   input  logic      flush_i,
   output logic      wb_valid_o,
   output wb_t       wb_o,
   output logic      exc_valid_o,
   output exc_t      exc_o
);

   logic            mem_req_valid;
   mem_req_t        mem_req;
   logic            mem_rsp_valid;
   mem_rsp_t        mem_rsp;
   logic            spr_req_valid;
   spr_req_t        spr_req;
   logic            spr_ack;
   logic [XLEN-1:0] spr_rdata;

   pipe_exec_ctrl i_exec_ctrl (
      .clk             (clk),
      .rst             (rst),
      .issue_pkt_i     (issue_pkt_i),
      .issue_valid_i   (issue_valid_i),
      .issue_ready_o   (issue_ready_o),
      .flush_i         (flush_i),
      .mem_req_valid_o (mem_req_valid),
      .mem_req_o       (mem_req),
      .mem_rsp_valid_i (mem_rsp_valid),
      .mem_rsp_i       (mem_rsp),
      .spr_req_valid_o (spr_req_valid),
      .spr_req_o       (spr_req),
      .spr_ack_i       (spr_ack),
      .spr_rdata_i     (spr_rdata),
      .wb_valid_o      (wb_valid_o),
      .wb_o            (wb_o),
      .exc_valid_o     (exc_valid_o),
      .exc_o           (exc_o)
   );

   pipe_dmem i_dmem (
      .clk         (clk),
      .rst         (rst),
      .req_valid_i (mem_req_valid),
      .req_i       (mem_req),
      .rsp_valid_o (mem_rsp_valid),
      .rsp_o       (mem_rsp)
   );

   pipe_spr_file i_spr_file (
      .clk         (clk),
      .rst         (rst),
      .req_valid_i (spr_req_valid),
      .req_i       (spr_req),
      .ack_o       (spr_ack),
      .rdata_o     (spr_rdata)
   );

endmodule

//--- tests/pipe_tail_chk.sv
`timescale 1ns/1ps

module pipe_tail_chk (
   input logic clk,
   input logic rst,
   input logic issue_ready_i,
   input logic wb_valid_i,
   input logic exc_valid_i,
   input logic mem_req_valid_i,
   input logic mem_pend_i,
   input logic mem_rsp_valid_i,
   input logic spr_req_valid_i,
   input logic spr_pend_i,
   input logic spr_ack_i
);

   // every instruction ends in at most one beat
   a_one_beat: assert property (@(posedge clk) disable iff (rst)
      !(wb_valid_i && exc_valid_i))
      else $error("writeback and exception beats are valid in the same cycle");

   a_mem_once: assert property (@(posedge clk) disable iff (rst)
      !(mem_req_valid_i && mem_pend_i))
      else $error("memory request issued while a memory access is pending");

   a_spr_once: assert property (@(posedge clk) disable iff (rst)
      !(spr_req_valid_i && spr_pend_i))
      else $error("spr request issued while an spr access is pending");

   // the stage must hold while a unit still owes its response
   a_hold: assert property (@(posedge clk) disable iff (rst)
      ((mem_pend_i && !mem_rsp_valid_i) || (spr_pend_i && !spr_ack_i)) |-> !issue_ready_i)
      else $error("issue_ready_o is high while a unit response is outstanding");

endmodule

bind pipe_exec_ctrl pipe_tail_chk i_chk (
   .clk             (clk),
   .rst             (rst),
   .issue_ready_i   (issue_ready_o),
   .wb_valid_i      (wb_valid_o),
   .exc_valid_i     (exc_valid_o),
   .mem_req_valid_i (mem_req_valid_o),
   .mem_pend_i      (mem_pend),
   .mem_rsp_valid_i (mem_rsp_valid_i),
   .spr_req_valid_i (spr_req_valid_o),
   .spr_pend_i      (spr_pend),
   .spr_ack_i       (spr_ack_i)
);

//--- tests/pipe_tail_tb.sv
`timescale 1ns/1ps

module pipe_tail_tb import pipe_pkg::*; ();

   localparam int  MAX_TESTS = 64;
   localparam time DRIVE_DLY = 10ns;

   // one line of the stimulus file
   // code holds the expected rd for a writeback and the expected cause for an exception
   typedef struct packed {
      logic [15:0]          id;
      logic [2:0]           op;
      logic [RF_ADDR_W-1:0] rd;
      logic [XLEN-1:0]      pc;
      logic [XLEN-1:0]      result;
      logic [XLEN-1:0]      opb;
      logic                 ill;
      logic                 sys;
      logic                 flush;
      logic [8*4-1:0]       kind;
      logic [RF_ADDR_W-1:0] code;
      logic [XLEN-1:0]      data;
   } stim_t;

   logic      clk;
   logic      rst;
   exec_pkt_t issue_pkt;
   logic      issue_valid;
   logic      issue_ready;
   logic      flush;
   logic      wb_valid;
   wb_t       wb;
   logic      exc_valid;
   exc_t      exc;

   stim_t       tests [MAX_TESTS];
   int          num_tests = 0;
   int          pass_cnt = 0;
   int          fail_cnt = 0;
   int          err_cnt = 0;
   int          cycles = 0;
   int          cycle_limit = 1000;
   wb_t         wb_q [$];
   exc_t        exc_q [$];

   pipe_tail i_dut (
      .clk           (clk),
      .rst           (rst),
      .issue_pkt_i   (issue_pkt),
      .issue_valid_i (issue_valid),
      .issue_ready_o (issue_ready),
      .flush_i       (flush),
      .wb_valid_o    (wb_valid),
      .wb_o          (wb),
      .exc_valid_o   (exc_valid),
      .exc_o         (exc)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // beats are single-cycle pulses, so they are collected in the middle of the cycle
   always @(negedge clk) begin
      if (!rst) begin
         if (wb_valid) begin
            wb_q.push_back(wb);
         end
         if (exc_valid) begin
            exc_q.push_back(exc);
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout after %0d cycles, the DUT stopped handing back the stage", cycles);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   task automatic load_stim();
      int                   fd;
      int                   rc;
      string                line;
      logic [15:0]          id;
      logic [2:0]           op;
      logic [RF_ADDR_W-1:0] rd;
      logic                 ill;
      logic                 sys;
      logic                 fl;
      logic [RF_ADDR_W-1:0] code;
      logic [XLEN-1:0]      pc, res, opb, data;
      logic [8*4-1:0]       kind;
      fd = $fopen("tests/pipe_tail_stim.txt", "r");
      if (fd == 0) begin
         $display("cannot open the stimulus file tests/pipe_tail_stim.txt");
         err_cnt++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#") begin
               rc = $sscanf(line, "%d %d %d %h %h %h %d %d %d %s %d %h", id, op, rd, pc,
                            res, opb, ill, sys, fl, kind, code, data);
               if (rc == 12 && num_tests < MAX_TESTS) begin
                  tests[num_tests] = '{id: id, op: op, rd: rd, pc: pc, result: res,
                                       opb: opb, ill: ill, sys: sys, flush: fl,
                                       kind: kind, code: code, data: data};
                  num_tests++;
               end else begin
                  $display("stimulus line could not be read: %s", line);
                  err_cnt++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic wait_ready();
      do begin
         @(negedge clk);
      end while (!issue_ready);
   endtask

   task automatic check_beats(input stim_t t);
      int errs;
      errs = 0;
      if (t.kind == "wb") begin
         if (wb_q.size() == 0) begin
            $display("test %0d: the expected writeback beat never arrived", t.id);
            errs++;
         end else begin
            if (wb_q[0].rd != t.code) begin
               $display("** Error at %0t: wb_o.rd expected %0d, got %0d", $time, t.code,
                        wb_q[0].rd);
               errs++;
            end
            if (wb_q[0].data != t.data) begin
               $display("** Error at %0t: wb_o.data expected %h, got %h", $time, t.data,
                        wb_q[0].data);
               errs++;
            end
         end
      end else if (t.kind == "exc") begin
         if (exc_q.size() == 0) begin
            $display("test %0d: the expected exception beat never arrived", t.id);
            errs++;
         end else begin
            if (5'(exc_q[0].cause) != t.code) begin
               $display("** Error at %0t: exc_o.cause expected %0d, got %0d", $time, t.code,
                        exc_q[0].cause);
               errs++;
            end
            if (exc_q[0].pc != t.data) begin
               $display("** Error at %0t: exc_o.pc expected %h, got %h", $time, t.data,
                        exc_q[0].pc);
               errs++;
            end
         end
      end else if (t.kind != "none") begin
         $display("test %0d: the stimulus names an unknown outcome", t.id);
         errs++;
      end
      if (wb_q.size() > ((t.kind == "wb") ? 1 : 0)) begin
         $display("test %0d: a writeback beat appeared that was not expected", t.id);
         errs++;
      end
      if (exc_q.size() > ((t.kind == "exc") ? 1 : 0)) begin
         $display("test %0d: an exception beat appeared that was not expected", t.id);
         errs++;
      end
      wb_q.delete();
      exc_q.delete();
      if (errs == 0) begin
         $display("test %0d passed", t.id);
         pass_cnt++;
      end else begin
         $display("test %0d failed", t.id);
         fail_cnt++;
      end
   endtask

   task automatic run_test(input stim_t t);
      int idle;
      idle = $urandom_range(3);
      repeat (idle) @(posedge clk);
      @(posedge clk);
      #(DRIVE_DLY);
      issue_pkt = '{op: op_e'(t.op), rd: t.rd, pc: t.pc, result: t.result, opb: t.opb,
                    exc_illegal: t.ill, exc_syscall: t.sys};
      issue_valid = 1'b1;
      wait_ready();
      @(posedge clk);
      #(DRIVE_DLY);
      issue_valid = 1'b0;
      // the flush lands one edge after the instruction entered ctrl
      if (t.flush) begin
         flush = 1'b1;
         @(posedge clk);
         #(DRIVE_DLY);
         flush = 1'b0;
      end
      wait_ready();
      // the completing edge, then one more so that the monitor has seen any beat
      @(posedge clk);
      @(posedge clk);
      check_beats(t);
   endtask

   initial begin
      rst = 1'b1;
      issue_pkt = '0;
      issue_valid = 1'b0;
      flush = 1'b0;
      void'($urandom(64));
      load_stim();
      cycle_limit = 10 * num_tests + 100;
      repeat (8) @(posedge clk);
      #(DRIVE_DLY);
      rst = 1'b0;
      for (int i = 0; i < num_tests; i++) begin
         run_test(tests[i]);
      end
      $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && err_cnt == 0 && num_tests > 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- tests/pipe_tail_stim.txt
# id op rd pc result opb illegal syscall flush kind code data (pc, result, opb, data in hex)
# op: 0 nop 1 alu 2 jal 3 load 4 store 5 mfspr 6 mtspr; code is rd for wb, cause for exc
1 1 5 00000100 0000abcd 00000000 0 0 0 wb 5 0000abcd
2 1 0 00000104 12345678 00000000 0 0 0 none 0 00000000
3 2 1 00000108 00000200 00000000 0 0 0 wb 1 0000010c
4 2 31 fffffffc 00000000 00000000 0 0 0 wb 31 00000000
5 0 3 0000010c 00000042 00000000 0 0 0 none 0 00000000
6 4 0 00000110 00000010 cafef00d 0 0 0 none 0 00000000
7 3 7 00000114 00000010 00000000 0 0 0 wb 7 cafef00d
8 3 8 00000118 00000020 00000000 0 0 0 wb 8 00000000
9 4 0 0000011c 000000fc 5a5a5a5a 0 0 0 none 0 00000000
10 3 9 00000120 000000fc 00000000 0 0 0 wb 9 5a5a5a5a
11 3 10 00000124 00000012 00000000 0 0 0 exc 3 00000124
12 4 0 00000128 00000011 deadbeef 0 0 0 exc 3 00000128
13 4 0 0000012c 00000100 deadbeef 0 0 0 exc 4 0000012c
14 3 11 00000130 00000000 00000000 0 0 0 wb 11 00000000
15 3 12 00000134 00000010 00000000 0 0 0 wb 12 cafef00d
16 3 13 00000138 00000400 00000000 0 0 0 exc 4 00000138
17 3 13 0000013c 00000402 00000000 0 0 0 exc 3 0000013c
18 1 4 00000140 11111111 00000000 1 0 0 exc 1 00000140
19 1 4 00000144 22222222 00000000 0 1 0 exc 2 00000144
20 1 4 00000148 33333333 00000000 1 1 0 exc 1 00000148
21 4 0 0000014c 00000002 00000000 1 0 0 exc 1 0000014c
22 6 0 00000150 00000003 0badf00d 0 0 0 none 0 00000000
23 5 14 00000154 00000003 00000000 0 0 0 wb 14 0badf00d
24 5 15 00000158 00000005 00000000 0 0 0 wb 15 00000000
25 6 0 0000015c 00000000 ffffffff 0 0 0 none 0 00000000
26 5 16 00000160 00000000 00000000 0 0 0 wb 16 00010001
27 3 17 00000164 00000010 00000000 0 0 1 none 0 00000000
28 1 18 00000168 00000777 00000000 0 0 0 wb 18 00000777
29 3 19 0000016c 00000010 00000000 0 0 1 none 0 00000000
30 3 20 00000170 000000fc 00000000 0 0 0 wb 20 5a5a5a5a

//--- pipe_tail.f
src/pipe_pkg.sv
src/pipe_spr_file.sv
src/pipe_dmem.sv
src/pipe_exec_ctrl.sv
src/pipe_tail.sv
tests/pipe_tail_chk.sv
tests/pipe_tail_tb.sv

//--- Bender.yml
package:
  name: pipe_tail

sources:
  - files:
      - src/pipe_pkg.sv
      - src/pipe_spr_file.sv
      - src/pipe_dmem.sv
      - src/pipe_exec_ctrl.sv
      - src/pipe_tail.sv
  - target: test
    files:
      - tests/pipe_tail_chk.sv
      - tests/pipe_tail_tb.sv
